//--- hw/butterfly_lane.sv
//**********************************************************************
// one output component, three register stages from operand to result
//**********************************************************************
`timescale 1ns/10ps
`include "sfp_config.svh"

module butterfly_lane (
  input  logic                clk,
  input  logic                rst,
  input  sfp_pkg::sfp_word_t  operand [`BFLY_POINTS],
  input  sfp_pkg::term_op_e   op [`BFLY_POINTS],
  output sfp_pkg::sfp_word_t  result
);

  sfp_pkg::sfp_exp_t max_exp;
  sfp_pkg::fix_t     aligned [`BFLY_POINTS];

  sfp_pkg::sfp_exp_t max_exp_q;
  sfp_pkg::fix_t     sum_q;

  exp_align i_exp_align (
    .clk     (clk),
    .rst     (rst),
    .operand (operand),
    .op      (op),
    .max_exp (max_exp),
    .aligned (aligned)
  );

  // four-input adder, fix width leaves room for the carry
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      sum_q     <= '0;
      max_exp_q <= '0;
    end else begin
      sum_q     <= aligned[0] + aligned[1] + aligned[2] + aligned[3];
      max_exp_q <= max_exp;
    end
  end

  fix_to_sfp i_fix_to_sfp (
    .sum     (sum_q),
    .max_exp (max_exp_q),
    .word    (result)
  );

endmodule

//--- hw/butterfly_operand_router.sv
//**********************************************************************
// takes a beat on every cycle with in_valid high, no back-pressure
// operand order per lane is point 0..3, W = -j rotation fixed in logic
//**********************************************************************
`timescale 1ns/10ps
`include "sfp_config.svh"

module butterfly_operand_router (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   in_valid,
  input  logic [`BFLY_POINTS*`SFP_WIDTH-1:0]     in_real,
  input  logic [`BFLY_POINTS*`SFP_WIDTH-1:0]     in_imag,
  output sfp_pkg::sfp_word_t                     lane_operand [`BFLY_LANES][`BFLY_POINTS],
  output sfp_pkg::term_op_e                      lane_op [`BFLY_LANES][`BFLY_POINTS],
  output logic                                   beat_valid
);

  sfp_pkg::sfp_word_t real_q [`BFLY_POINTS];
  sfp_pkg::sfp_word_t imag_q [`BFLY_POINTS];

  // input beat register, held while no beat arrives
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      beat_valid <= 1'b0;
      for (int n = 0; n < `BFLY_POINTS; n++) begin
        real_q[n] <= '0;
        imag_q[n] <= '0;
      end
    end else begin
      beat_valid <= in_valid;
      if (in_valid) begin
        for (int n = 0; n < `BFLY_POINTS; n++) begin
          real_q[n] <= in_real[n*`SFP_WIDTH +: `SFP_WIDTH];
          imag_q[n] <= in_imag[n*`SFP_WIDTH +: `SFP_WIDTH];
        end
      end
    end
  end

  // lane 2k is Re Xk, lane 2k+1 is Im Xk
  // twiddle for point n is (-j)^(n*k), only its index mod 4 matters
  for (genvar l = 0; l < `BFLY_LANES; l++) begin : g_lane
    for (genvar n = 0; n < `BFLY_POINTS; n++) begin : g_term
      localparam int ROT = (n * (l / 2)) % 4;
      localparam bit IS_IM = (l % 2) == 1;

      // odd rotations swap real and imaginary parts
      localparam bit USE_REAL = (ROT % 2) == (l % 2);

      // Re: +r, +i, -r, -i   Im: +i, -r, -i, +r
      localparam bit SUB = IS_IM ? ((((ROT >> 1) ^ ROT) % 2) == 1) : (ROT >= 2);

      assign lane_operand[l][n] = USE_REAL ? real_q[n] : imag_q[n];
      assign lane_op[l][n] = SUB ? sfp_pkg::TERM_SUB : sfp_pkg::TERM_ADD;
    end
  end

endmodule

//--- hw/exp_align.sv
//**********************************************************************
// two register stages, max_exp leaves aligned with the shifted terms
// shifts truncate, terms far below the max exponent drop to zero
//**********************************************************************
`timescale 1ns/10ps
`include "sfp_config.svh"

module exp_align (
  input  logic                clk,
  input  logic                rst,
  input  sfp_pkg::sfp_word_t  operand [`BFLY_POINTS],
  input  sfp_pkg::term_op_e   op [`BFLY_POINTS],
  output sfp_pkg::sfp_exp_t   max_exp,
  output sfp_pkg::fix_t       aligned [`BFLY_POINTS]
);

  // significand with hidden one, then with guard bits appended
  localparam int SIG_W = `SFP_SIG_WIDTH + 1;
  localparam int MAG_W = SIG_W + `SFP_LOW_EXPAND;

  sfp_pkg::sfp_exp_t exp_in [`BFLY_POINTS];
  sfp_pkg::sfp_exp_t max_exp_d;

  sfp_pkg::sfp_exp_t max_exp_s1;
  sfp_pkg::sfp_exp_t shift_s1 [`BFLY_POINTS];
  logic              neg_s1 [`BFLY_POINTS];
  logic [SIG_W-1:0]  mag_s1 [`BFLY_POINTS];

  logic [MAG_W-1:0]  shifted [`BFLY_POINTS];
  sfp_pkg::fix_t     term_d [`BFLY_POINTS];

  for (genvar n = 0; n < `BFLY_POINTS; n++) begin : g_exp
    assign exp_in[n] = operand[n][`SFP_WIDTH-2 -: `SFP_EXP_WIDTH];
  end

  // largest exponent of the four terms
  always_comb begin
    max_exp_d = '0;
    for (int n = 0; n < `BFLY_POINTS; n++) begin
      if (exp_in[n] > max_exp_d) begin
        max_exp_d = exp_in[n];
      end
    end
  end

  // stage 1: shift counts, term signs, significands
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      max_exp_s1 <= '0;
      for (int n = 0; n < `BFLY_POINTS; n++) begin
        shift_s1[n] <= '0;
        neg_s1[n]   <= 1'b0;
        mag_s1[n]   <= '0;
      end
    end else begin
      max_exp_s1 <= max_exp_d;
      for (int n = 0; n < `BFLY_POINTS; n++) begin
        shift_s1[n] <= max_exp_d - exp_in[n];
        neg_s1[n]   <= operand[n][`SFP_WIDTH-1] ^ (op[n] == sfp_pkg::TERM_SUB);
        // zero exponent means a zero term, no hidden one
        mag_s1[n]   <= (exp_in[n] == '0) ? '0 : {1'b1, operand[n][`SFP_SIG_WIDTH-1:0]};
      end
    end
  end

  always_comb begin
    for (int n = 0; n < `BFLY_POINTS; n++) begin
      shifted[n] = {mag_s1[n], {`SFP_LOW_EXPAND{1'b0}}} >> shift_s1[n];
      term_d[n]  = neg_s1[n] ? -sfp_pkg::fix_t'(shifted[n]) : sfp_pkg::fix_t'(shifted[n]);
    end
  end

  // stage 2: signed aligned terms
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      max_exp <= '0;
      for (int n = 0; n < `BFLY_POINTS; n++) begin
        aligned[n] <= '0;
      end
    end else begin
      max_exp <= max_exp_s1;
      for (int n = 0; n < `BFLY_POINTS; n++) begin
        aligned[n] <= term_d[n];
      end
    end
  end

endmodule

//--- hw/fix_to_sfp.sv
//**********************************************************************
// purely combinational, mantissa truncates toward zero magnitude
// exponent above 15 saturates, below 1 flushes to the zero word
//**********************************************************************
`timescale 1ns/10ps
`include "sfp_config.svh"

module fix_to_sfp (
  input  sfp_pkg::fix_t       sum,
  input  sfp_pkg::sfp_exp_t   max_exp,
  output sfp_pkg::sfp_word_t  word
);

  localparam int FIX_W   = `SFP_FIX_WIDTH;
  localparam int EXP_W   = `SFP_EXP_WIDTH;
  localparam int SIG_W   = `SFP_SIG_WIDTH;
  localparam int POS_W   = $clog2(FIX_W);
  // bit where the hidden one sits for an unshifted term
  localparam int NOMINAL = `SFP_SIG_WIDTH + `SFP_LOW_EXPAND;
  localparam int EXP_MAX = (1 << EXP_W) - 1;

  logic             neg;
  logic [FIX_W-1:0] mag;
  logic [POS_W-1:0] lead_pos;
  logic [FIX_W-1:0] norm;
  logic [SIG_W-1:0] mant;
  int               exp_full;

  assign neg = sum[FIX_W-1];
  assign mag = neg ? -sum : sum;

  // leading one, highest set bit wins
  always_comb begin
    lead_pos = '0;
    for (int i = 0; i < FIX_W; i++) begin
      if (mag[i]) begin
        lead_pos = POS_W'(i);
      end
    end
  end

  // leading one moved to the top, the bits below it are the mantissa
  assign norm = mag << (FIX_W - 1 - lead_pos);
  assign mant = norm[FIX_W-2 -: SIG_W];

  assign exp_full = int'(max_exp) + int'(lead_pos) - NOMINAL;

  always_comb begin
    if (mag == '0 || exp_full < 1) begin
      word = '0;
    end else if (exp_full > EXP_MAX) begin
      word = {neg, {EXP_W{1'b1}}, {SIG_W{1'b1}}};
    end else begin
      word = {neg, exp_full[EXP_W-1:0], mant};
    end
  end

endmodule

//--- hw/radix4_butterfly.sv
//**********************************************************************
// radix-4 sfp butterfly, one beat per cycle, out_valid 5 cycles later
// no back-pressure, the consumer must take every output beat
//**********************************************************************
`timescale 1ns/10ps
`include "sfp_config.svh"

module radix4_butterfly (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               in_valid,
  input  logic [`BFLY_POINTS*`SFP_WIDTH-1:0] in_real,
  input  logic [`BFLY_POINTS*`SFP_WIDTH-1:0] in_imag,
  output logic [`BFLY_POINTS*`SFP_WIDTH-1:0] out_real,
  output logic [`BFLY_POINTS*`SFP_WIDTH-1:0] out_imag,
  output logic                               out_valid
);

  sfp_pkg::sfp_word_t lane_operand [`BFLY_LANES][`BFLY_POINTS];
  sfp_pkg::term_op_e  lane_op [`BFLY_LANES][`BFLY_POINTS];
  sfp_pkg::sfp_word_t lane_result [`BFLY_LANES];
  logic               beat_valid;

  butterfly_operand_router i_router (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_real      (in_real),
    .in_imag      (in_imag),
    .lane_operand (lane_operand),
    .lane_op      (lane_op),
    .beat_valid   (beat_valid)
  );

  // every lane has its own exponent group
  for (genvar l = 0; l < `BFLY_LANES; l++) begin : g_lane
    butterfly_lane i_lane (
      .clk     (clk),
      .rst     (rst),
      .operand (lane_operand[l]),
      .op      (lane_op[l]),
      .result  (lane_result[l])
    );
  end

  result_packer i_packer (
    .clk         (clk),
    .rst         (rst),
    .beat_valid  (beat_valid),
    .lane_result (lane_result),
    .out_real    (out_real),
    .out_imag    (out_imag),
    .out_valid   (out_valid)
  );

endmodule

//--- hw/result_packer.sv
//**********************************************************************
// valid delay line must match the lane depth (LANE_STAGES)
// outputs hold the last beat until the next valid one
//**********************************************************************
`timescale 1ns/10ps
`include "sfp_config.svh"

module result_packer (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               beat_valid,
  input  sfp_pkg::sfp_word_t                 lane_result [`BFLY_LANES],
  output logic [`BFLY_POINTS*`SFP_WIDTH-1:0] out_real,
  output logic [`BFLY_POINTS*`SFP_WIDTH-1:0] out_imag,
  output logic                               out_valid
);

  logic [`LANE_STAGES-1:0] valid_pipe;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      valid_pipe <= '0;
      out_valid  <= 1'b0;
      out_real   <= '0;
      out_imag   <= '0;
    end else begin
      valid_pipe <= {valid_pipe[`LANE_STAGES-2:0], beat_valid};
      out_valid  <= valid_pipe[`LANE_STAGES-1];
      if (valid_pipe[`LANE_STAGES-1]) begin
        // even lanes are real parts, X0 in the low word
        for (int k = 0; k < `BFLY_POINTS; k++) begin
          out_real[k*`SFP_WIDTH +: `SFP_WIDTH] <= lane_result[2*k];
          out_imag[k*`SFP_WIDTH +: `SFP_WIDTH] <= lane_result[2*k+1];
        end
      end
    end
  end

endmodule

//--- hw/sfp_config.svh
//**********************************************************************
// sfp format and butterfly sizing, widths must agree with each other
// SFP_FIX_WIDTH has to hold the sum of four aligned terms plus a sign
//**********************************************************************
`ifndef SFP_CONFIG_SVH
`define SFP_CONFIG_SVH

// word layout is sign, exponent, mantissa
`define SFP_EXP_WIDTH 4
`define SFP_SIG_WIDTH 4
`define SFP_WIDTH 9
`define SFP_BIAS 7

// guard bits kept below the hidden one while aligning
`define SFP_LOW_EXPAND 3
`define SFP_FIX_WIDTH 11

// radix-4 butterfly geometry
`define BFLY_POINTS 4
`define BFLY_LANES 8

// registers inside one lane, align (2) plus sum (1)
`define LANE_STAGES 3

`endif

//--- hw/sfp_pkg.sv
//**********************************************************************
// types shared by the butterfly datapath, widths come from the config
//**********************************************************************
`include "sfp_config.svh"

package sfp_pkg;

  // one packed sfp word, sign in the top bit
  typedef logic [`SFP_WIDTH-1:0] sfp_word_t;

  // biased exponent, zero means the value is zero
  typedef logic [`SFP_EXP_WIDTH-1:0] sfp_exp_t;

  // aligned two's complement term or four-term sum
  typedef logic signed [`SFP_FIX_WIDTH-1:0] fix_t;

  // sign applied to one term before the lane adder
  typedef enum logic {
    TERM_ADD = 1'b0,
    TERM_SUB = 1'b1
  } term_op_e;

endpackage

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module radix4_butterfly_tb -f verilog.f \
  --Mdir obj_dir -o radix4_butterfly_sim &&
result="$(./obj_dir/radix4_butterfly_sim)" &&
printf '%s\n' "$result" &&
printf '%s\n' "$result" | grep -q "All tests passed" ||
{ echo "simulation did not pass"; exit 1; }
exit 0

//--- sim/butterfly_model.svh
//**********************************************************************
// reference model of the sfp radix-4 butterfly, bit exact, W = -j
// expects sfp_config.svh to be included before this file
//**********************************************************************
`ifndef BUTTERFLY_MODEL_SVH
`define BUTTERFLY_MODEL_SVH

// four signed sfp terms summed after block exponent alignment
function automatic logic [`SFP_WIDTH-1:0] lane_sum(
  input logic [`BFLY_POINTS*`SFP_WIDTH-1:0] ops,
  input logic [`BFLY_POINTS-1:0]            subs
);
  logic [`SFP_WIDTH-1:0] w;
  logic                  neg;
  int                    max_e;
  int                    e;
  int                    term;
  int                    sum;
  int                    mag;
  int                    lead;
  int                    ex;
  int                    mant;
  max_e = 0;
  sum = 0;
  for (int n = 0; n < `BFLY_POINTS; n++) begin
    w = ops[n*`SFP_WIDTH +: `SFP_WIDTH];
    e = int'(w[`SFP_WIDTH-2 -: `SFP_EXP_WIDTH]);
    if (e > max_e) begin
      max_e = e;
    end
  end
  for (int n = 0; n < `BFLY_POINTS; n++) begin
    w = ops[n*`SFP_WIDTH +: `SFP_WIDTH];
    e = int'(w[`SFP_WIDTH-2 -: `SFP_EXP_WIDTH]);
    // exponent zero is a zero term
    if (e != 0) begin
      term = ((1 << `SFP_SIG_WIDTH) + int'(w[`SFP_SIG_WIDTH-1:0])) << `SFP_LOW_EXPAND;
      term = term >> (max_e - e);
      if (w[`SFP_WIDTH-1] ^ subs[n]) begin
        term = -term;
      end
      sum = sum + term;
    end
  end
  if (sum == 0) begin
    return '0;
  end
  neg = (sum < 0);
  mag = neg ? -sum : sum;
  lead = 0;
  for (int i = 0; i < 32; i++) begin
    if (mag[i]) begin
      lead = i;
    end
  end
  ex = max_e + lead - (`SFP_SIG_WIDTH + `SFP_LOW_EXPAND);
  if (ex < 1) begin
    return '0;
  end
  if (ex > (1 << `SFP_EXP_WIDTH) - 1) begin
    return {neg, {`SFP_EXP_WIDTH{1'b1}}, {`SFP_SIG_WIDTH{1'b1}}};
  end
  // four bits below the leading one, zero filled when short
  if (lead >= `SFP_SIG_WIDTH) begin
    mant = mag >> (lead - `SFP_SIG_WIDTH);
  end else begin
    mant = mag << (`SFP_SIG_WIDTH - lead);
  end
  return {neg, ex[`SFP_EXP_WIDTH-1:0], mant[`SFP_SIG_WIDTH-1:0]};
endfunction

// returns {imag outputs, real outputs}, X0 in the low word of each
function automatic logic [2*`BFLY_POINTS*`SFP_WIDTH-1:0] bfly_ref(
  input logic [`BFLY_POINTS*`SFP_WIDTH-1:0] re,
  input logic [`BFLY_POINTS*`SFP_WIDTH-1:0] im
);
  logic [`BFLY_POINTS*`SFP_WIDTH-1:0] mix_a;
  logic [`BFLY_POINTS*`SFP_WIDTH-1:0] mix_b;
  logic [`BFLY_POINTS*`SFP_WIDTH-1:0] out_re;
  logic [`BFLY_POINTS*`SFP_WIDTH-1:0] out_im;
  // r0 i1 r2 i3 and i0 r1 i2 r3, the odd-output mixes
  mix_a = {im[3*`SFP_WIDTH +: `SFP_WIDTH], re[2*`SFP_WIDTH +: `SFP_WIDTH],
           im[`SFP_WIDTH +: `SFP_WIDTH], re[0 +: `SFP_WIDTH]};
  mix_b = {re[3*`SFP_WIDTH +: `SFP_WIDTH], im[2*`SFP_WIDTH +: `SFP_WIDTH],
           re[`SFP_WIDTH +: `SFP_WIDTH], im[0 +: `SFP_WIDTH]};
  out_re[0 +: `SFP_WIDTH] = lane_sum(re, 4'b0000);
  out_im[0 +: `SFP_WIDTH] = lane_sum(im, 4'b0000);
  out_re[`SFP_WIDTH +: `SFP_WIDTH] = lane_sum(mix_a, 4'b1100);
  out_im[`SFP_WIDTH +: `SFP_WIDTH] = lane_sum(mix_b, 4'b0110);
  out_re[2*`SFP_WIDTH +: `SFP_WIDTH] = lane_sum(re, 4'b1010);
  out_im[2*`SFP_WIDTH +: `SFP_WIDTH] = lane_sum(im, 4'b1010);
  out_re[3*`SFP_WIDTH +: `SFP_WIDTH] = lane_sum(mix_a, 4'b0110);
  out_im[3*`SFP_WIDTH +: `SFP_WIDTH] = lane_sum(mix_b, 4'b1100);
  return {out_im, out_re};
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] state);
  logic [31:0] x;
  x = state;
  x ^= x << 13;
  x ^= x >> 17;
  x ^= x << 5;
  return x;
endfunction

`endif

//--- sim/radix4_butterfly_tb.sv
//**********************************************************************
// self-checking testbench, outputs sampled on the falling clock edge
// latency counted from the edge after which a beat is driven
//**********************************************************************
`timescale 1ns/10ps
`include "sfp_config.svh"

module radix4_butterfly_tb;

  `include "butterfly_model.svh"

  localparam int BUS_W = `BFLY_POINTS * `SFP_WIDTH;
  localparam int RESET_CYCLES = 10;
  localparam int LATENCY = 5;
  localparam int STREAM_BEATS = 200;
  localparam int GAP_BEATS = 100;
  localparam int MAX_GAP = 3;
  localparam int NUM_TESTS = 5;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 5 + STREAM_BEATS
                                  + GAP_BEATS * (MAX_GAP + 1)
                                  + NUM_TESTS * (LATENCY + 4) + 100;

  localparam logic [`SFP_WIDTH-1:0] ONE = 9'h070;
  localparam logic [`SFP_WIDTH-1:0] NEG_ONE = 9'h170;

  logic             clk;
  logic             rst;
  logic             in_valid;
  logic [BUS_W-1:0] in_real;
  logic [BUS_W-1:0] in_imag;
  logic [BUS_W-1:0] out_real;
  logic [BUS_W-1:0] out_imag;
  logic             out_valid;

  logic [2*BUS_W-1:0] expect_q [$];
  int                 launch_q [$];
  logic [2*BUS_W-1:0] expected;
  int                 launch;
  logic [31:0]        rng_state = 32'hf758_8161;
  int                 cycle_cnt = 0;
  int                 errors = 0;
  int                 err_at_start;
  int                 tests_run = 0;
  int                 tests_failed = 0;

  radix4_butterfly i_dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_real   (in_real),
    .in_imag   (in_imag),
    .out_real  (out_real),
    .out_imag  (out_imag),
    .out_valid (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic check_value(input string name, input logic [BUS_W-1:0] got,
                             input logic [BUS_W-1:0] want);
    if (got !== want) begin
      $display("mismatch %s: got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic start_test();
    err_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_at_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - err_at_start);
    end
  endtask

  task automatic random_beat(output logic [BUS_W-1:0] re, output logic [BUS_W-1:0] im);
    for (int n = 0; n < `BFLY_POINTS; n++) begin
      rng_state = xorshift32(rng_state);
      re[n*`SFP_WIDTH +: `SFP_WIDTH] = rng_state[31 -: `SFP_WIDTH];
      rng_state = xorshift32(rng_state);
      im[n*`SFP_WIDTH +: `SFP_WIDTH] = rng_state[31 -: `SFP_WIDTH];
    end
  endtask

  task automatic send_beat(input logic [BUS_W-1:0] re, input logic [BUS_W-1:0] im,
                           input logic [2*BUS_W-1:0] want);
    @(posedge clk);
    #1;
    in_valid = 1'b1;
    in_real = re;
    in_imag = im;
    expect_q.push_back(want);
    launch_q.push_back(cycle_cnt);
  endtask

  // idle cycle with random data, which the DUT must ignore
  task automatic idle_cycle();
    logic [BUS_W-1:0] re;
    logic [BUS_W-1:0] im;
    random_beat(re, im);
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    in_real = re;
    in_imag = im;
  endtask

  // outstanding beats get a few cycles past the latency to come out
  task automatic drain();
    int waited;
    waited = 0;
    idle_cycle();
    while (expect_q.size() != 0 && waited < LATENCY + 2) begin
      @(posedge clk);
      waited++;
    end
    if (expect_q.size() != 0) begin
      $display("%0d beats did not come out in time", expect_q.size());
      errors++;
    end
  endtask

  // compare process, one expected entry per out_valid
  always @(negedge clk) begin
    if (rst && out_valid) begin
      if (expect_q.size() == 0) begin
        $display("out_valid high at cycle %0d with no beat outstanding", cycle_cnt);
        errors++;
      end else begin
        expected = expect_q.pop_front();
        launch = launch_q.pop_front();
        check_value("out_real", out_real, expected[BUS_W-1:0]);
        check_value("out_imag", out_imag, expected[2*BUS_W-1:BUS_W]);
        if (cycle_cnt - launch != LATENCY) begin
          $display("beat launched at cycle %0d came out after %0d cycles instead of %0d",
                   launch, cycle_cnt - launch, LATENCY);
          errors++;
        end
      end
    end
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("run stopped by timeout after %0d cycles", cycle_cnt);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    logic [BUS_W-1:0] re;
    logic [BUS_W-1:0] im;
    int gap;
    rst = 1'b0;
    in_valid = 1'b0;
    in_real = '0;
    in_imag = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b1;

    start_test();
    @(negedge clk);
    check_value("out_valid", BUS_W'(out_valid), '0);
    check_value("out_real", out_real, '0);
    check_value("out_imag", out_imag, '0);
    end_test("reset");

    // x0 = 1 gives all ones, x1 = 1 rotates by -j per output
    start_test();
    send_beat({27'b0, ONE}, '0, {36'b0, ONE, ONE, ONE, ONE});
    send_beat({18'b0, ONE, 9'b0}, '0,
              {ONE, 9'b0, NEG_ONE, 9'b0, 9'b0, NEG_ONE, 9'b0, ONE});
    drain();
    end_test("impulse");

    start_test();
    for (int b = 0; b < STREAM_BEATS; b++) begin
      random_beat(re, im);
      send_beat(re, im, bfly_ref(re, im));
    end
    drain();
    end_test("stream");

    // r0 = r1 = 1.5 cancels in Re X2, all 0x0ff saturates Re X0
    start_test();
    send_beat({18'b0, 9'h078, 9'h078}, '0,
              {9'h078, 9'h000, 9'h178, 9'h000, 9'h078, 9'h000, 9'h078, 9'h088});
    send_beat({4{9'h0ff}}, '0, {36'b0, 27'b0, 9'h0ff});
    // exponent 2 term vanishes beside exponent 15
    send_beat({18'b0, 9'h02f, 9'h0f0}, '0,
              {9'h02f, 9'h000, 9'h12f, 9'h000, {4{9'h0f0}}});
    drain();
    end_test("edge values");

    start_test();
    for (int b = 0; b < GAP_BEATS; b++) begin
      random_beat(re, im);
      send_beat(re, im, bfly_ref(re, im));
      rng_state = xorshift32(rng_state);
      gap = int'(rng_state % (MAX_GAP + 1));
      repeat (gap) idle_cycle();
    end
    drain();
    end_test("latency with gaps");

    if (expect_q.size() != 0) begin
      $display("%0d beats never came out", expect_q.size());
      errors++;
    end
    $display("tests run %0d, ok %0d, failing %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hw
+incdir+sim
hw/sfp_pkg.sv
hw/butterfly_operand_router.sv
hw/exp_align.sv
hw/fix_to_sfp.sv
hw/butterfly_lane.sv
hw/result_packer.sv
hw/radix4_butterfly.sv
sim/radix4_butterfly_tb.sv
